/* compile.f */
verilog/wb_pkg.sv
verilog/wb_stage.sv
verilog/csr_file.sv
verilog/reg_file.sv
verilog/tlb_array.sv
verilog/wb_subsys_top.sv
tb/tb_wb_subsys.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_wb_subsys \
    -f compile.f \
    -o sim_wb_subsys

./obj_dir/sim_wb_subsys

/* tb/tb_wb_subsys.sv */
`timescale 1ns/1ps

module tb_wb_subsys;
    import wb_pkg::*;

    localparam int TLB_NUM   = 16;
    localparam int IDX_W     = $clog2(TLB_NUM);
    localparam int N_INSTR   = 3000;
    localparam int MAX_CYCLE = 2 * N_INSTR + 100;

    localparam csr_num_e CSR_LIST [14] = '{CSR_CRMD, CSR_PRMD, CSR_ESTAT, CSR_ERA, CSR_BADV,
        CSR_EENTRY, CSR_TLBIDX, CSR_TLBEHI, CSR_TLBELO0, CSR_ASID, CSR_TID, CSR_TLBRENTRY,
        CSR_DMW0, CSR_DMW1};
    localparam ecode_e ECODE_LIST [5] = '{ECODE_ADEF, ECODE_SYS, ECODE_BRK, ECODE_INE,
        ECODE_TLBR};

    logic        clk;
    logic        resetn;
    logic        mem_to_wb_valid;
    mem_wb_t     mem_to_wb_bus;
    logic        wb_allowin;
    logic        ex_flush;
    logic        ertn_flush;
    logic        refetch_flush;
    logic [31:0] flush_entry;
    logic        wb_to_ex_conflict;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;
    rf_wb_t      rf_wb;
    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    logic [31:0] rdata1;
    logic [31:0] rdata2;

    // reference model
    logic [31:0]        csr_m [16384];  // indexed by csr number
    logic [31:0]        regs_m [32];
    logic [31:0]        reg_known;      // written since reset
    tlb_entry_t         tlb_m [TLB_NUM];
    logic [TLB_NUM-1:0] tlb_v;
    int                 victim_m;
    logic               in_wb;          // model holds an instruction in writeback
    mem_wb_t            wb_m;
    logic [31:0]        rng;
    int                 cycle = 0;

    wb_subsys_top #(.TLB_NUM(TLB_NUM)) i_wb_subsys_top (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLE) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLE);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // architectural writable fields of each csr
    function automatic logic [31:0] writable_bits(input csr_num_e num);
        case (num)
            CSR_CRMD:                  return 32'h0000_01ff;
            CSR_PRMD:                  return 32'h0000_0007;
            CSR_ESTAT:                 return 32'h0000_0003; // software irq bits only
            CSR_EENTRY, CSR_TLBRENTRY: return 32'hffff_ffc0;
            CSR_TLBIDX:                return 32'h8000_0000 | (TLB_NUM - 1);
            CSR_TLBEHI:                return 32'hffff_e000;
            CSR_TLBELO0:               return 32'h0fff_ff7f;
            CSR_ASID:                  return 32'h0000_03ff;
            CSR_DMW0, CSR_DMW1:        return 32'hee00_0039;
            default:                   return 32'hffff_ffff;
        endcase
    endfunction

    function automatic logic causes_flush(input mem_wb_t b);
        logic tlb_rf;
        logic csr_rf;
        tlb_rf = b.tlb_op inside {TLB_WR, TLB_FILL, TLB_RD, TLB_INV};
        csr_rf = b.csr_we && (b.csr_num inside {CSR_CRMD, CSR_ASID, CSR_DMW0, CSR_DMW1});
        return b.excep_en || b.ertn || tlb_rf || csr_rf;
    endfunction

    function automatic logic [31:0] expected_result(input mem_wb_t b);
        if (b.read_tid) begin
            return csr_m[CSR_TID];
        end else if (b.csr_re) begin
            return csr_m[b.csr_num];
        end
        return b.rf_wdata;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic check_regs();
        if (reg_known[raddr1]) begin
            check_value("reg read port 1", regs_m[raddr1], rdata1);
        end
        if (reg_known[raddr2]) begin
            check_value("reg read port 2", regs_m[raddr2], rdata2);
        end
    endtask

    task automatic check_wb();
        logic        ok;
        logic        refetch;
        logic [31:0] entry;
        string       name;
        check_value("allowin", 32'd1, 32'(wb_allowin)); // wb never stalls
        if (!in_wb) begin
            // empty or killed slot
            check_value("drop rf_we", 32'd0, 32'(debug_wb_rf_we));
            check_value("drop rf_wb we", 32'd0, 32'(rf_wb.we));
            check_value("drop flush", 32'd0, 32'({ex_flush, ertn_flush, refetch_flush}));
            check_value("drop conflict", 32'd0, 32'(wb_to_ex_conflict));
        end else begin
            ok      = !wb_m.excep_en && !wb_m.ertn;
            refetch = ok && causes_flush(wb_m);
            if (wb_m.excep_en) begin
                name  = "exception";
                entry = (wb_m.ecode == ECODE_TLBR) ? csr_m[CSR_TLBRENTRY] : csr_m[CSR_EENTRY];
            end else if (wb_m.ertn) begin
                name  = "ertn";
                entry = csr_m[CSR_ERA];
            end else begin
                name  = (wb_m.tlb_op != TLB_NONE) ? "tlb" : wb_m.csr_re ? "csr" : "alu";
                entry = wb_m.pc + 32'd4;
            end
            check_value({name, " flushes"}, 32'({wb_m.excep_en, wb_m.ertn, refetch}),
                        32'({ex_flush, ertn_flush, refetch_flush}));
            if (!ok || refetch) begin
                check_value({name, " flush_entry"}, entry, flush_entry);
            end
            check_value({name, " pc"}, wb_m.pc, debug_wb_pc);
            check_value({name, " rf_we"}, 32'({4{ok && wb_m.rf_we}}), 32'(debug_wb_rf_we));
            check_value({name, " rf_wb we"}, 32'(ok && wb_m.rf_we), 32'(rf_wb.we));
            if (ok && wb_m.rf_we) begin
                check_value({name, " wnum"}, 32'(wb_m.rf_waddr), 32'(debug_wb_rf_wnum));
                check_value({name, " wdata"}, expected_result(wb_m), debug_wb_rf_wdata);
                check_value({name, " rf_wb waddr"}, 32'(wb_m.rf_waddr), 32'(rf_wb.waddr));
                check_value({name, " rf_wb wdata"}, expected_result(wb_m), rf_wb.wdata);
            end
            check_value({name, " conflict"}, 32'(wb_m.srch_conflict), 32'(wb_to_ex_conflict));
        end
    endtask

    // state changes at the edge closing the writeback cycle
    task automatic retire_model();
        tlb_entry_t ent;
        int         slot;
        logic [31:0] m;
        if (in_wb && wb_m.excep_en) begin
            csr_m[CSR_PRMD][2:0]    = csr_m[CSR_CRMD][2:0];
            csr_m[CSR_CRMD][2:0]    = 3'b000;
            csr_m[CSR_ESTAT][30:16] = {wb_m.esubcode, wb_m.ecode};
            csr_m[CSR_ERA]          = wb_m.pc;
            if (wb_m.ecode inside {ECODE_ADEF, ECODE_TLBR}) begin
                csr_m[CSR_BADV] = wb_m.badv;
            end
        end else if (in_wb && wb_m.ertn) begin
            csr_m[CSR_CRMD][2:0] = csr_m[CSR_PRMD][2:0];
        end else if (in_wb) begin
            if (wb_m.rf_we && wb_m.rf_waddr != 5'd0) begin
                regs_m[wb_m.rf_waddr]    = expected_result(wb_m);
                reg_known[wb_m.rf_waddr] = 1'b1;
            end
            if (wb_m.csr_we) begin
                m = wb_m.csr_wmask & writable_bits(wb_m.csr_num);
                csr_m[wb_m.csr_num] = (csr_m[wb_m.csr_num] & ~m) | (wb_m.csr_wvalue & m);
            end
            // a written entry is valid unless NE is set
            ent = '{e: !csr_m[CSR_TLBIDX][31], vppn: csr_m[CSR_TLBEHI][31:13],
                    asid: csr_m[CSR_ASID][9:0], ppn: csr_m[CSR_TLBELO0][27:8],
                    plv: csr_m[CSR_TLBELO0][3:2]};
            slot = int'(csr_m[CSR_TLBIDX][IDX_W-1:0]);
            case (wb_m.tlb_op)
                TLB_SRCH: begin
                    csr_m[CSR_TLBIDX][31] = !wb_m.srch_found;
                    if (wb_m.srch_found) begin
                        csr_m[CSR_TLBIDX][IDX_W-1:0] = wb_m.srch_idx[IDX_W-1:0];
                    end
                end
                TLB_WR: begin
                    tlb_m[slot] = ent;
                    tlb_v[slot] = ent.e;
                end
                TLB_FILL: begin
                    tlb_m[victim_m] = ent;
                    tlb_v[victim_m] = ent.e;
                    victim_m        = (victim_m + 1) % TLB_NUM;
                end
                TLB_RD: begin
                    if (tlb_v[slot]) begin
                        csr_m[CSR_TLBIDX][31] = 1'b0;
                        csr_m[CSR_TLBEHI]     = {tlb_m[slot].vppn, 13'b0};
                        csr_m[CSR_TLBELO0]    = {4'b0, tlb_m[slot].ppn, 4'b0, tlb_m[slot].plv,
                                                 2'b01};
                        csr_m[CSR_ASID][9:0]  = tlb_m[slot].asid;
                    end else begin
                        csr_m[CSR_TLBIDX][31] = 1'b1;
                    end
                end
                TLB_INV: tlb_v = '0;
                default: ;
            endcase
        end
    endtask

    task automatic make_instr(output logic v, output mem_wb_t b);
        logic [31:0] r;
        logic [31:0] x;
        int          kind;
        r    = next_rand();
        x    = next_rand();
        kind = int'(r[11:8]);
        b    = '0;
        v    = kind < 14;           // 14 and 15 are bubbles
        b.pc            = {x[31:2], 2'b00};
        b.rf_waddr      = r[4:0];
        b.rf_wdata      = next_rand();
        b.srch_conflict = r[31];
        if (kind < 5) begin
            b.rf_we = 1'b1;
        end else if (kind < 10) begin
            b.rf_we      = 1'b1;
            b.csr_re     = 1'b1;
            b.csr_we     = r[12];
            b.read_tid   = !r[12] && r[14:13] == 2'b00;
            b.csr_num    = CSR_LIST[int'(r[19:16]) % 14];
            b.csr_wmask  = next_rand();
            b.csr_wvalue = next_rand();
        end else if (kind == 10) begin
            b.excep_en = 1'b1;
            b.rf_we    = r[12];     // has to be suppressed
            b.ecode    = ECODE_LIST[int'(r[18:16]) % 5];
            b.esubcode = r[28:20];
            b.badv     = next_rand();
        end else if (kind == 11) begin
            b.ertn = 1'b1;
        end else begin
            b.tlb_op     = tlb_op_e'(3'(1 + int'(r[18:16]) % 5));
            b.srch_found = r[20];
            b.srch_idx   = r[24:21];
        end
    endtask

    initial begin
        mem_wb_t     nb;
        logic        nv;
        logic        flushing;
        logic [31:0] x;
        resetn          = 1'b0;
        mem_to_wb_valid = 1'b0;
        mem_to_wb_bus   = '0;
        raddr1          = 5'd0;
        raddr2          = 5'd0;
        rng             = 32'h65c0;
        for (int i = 0; i < 16384; i++) begin
            csr_m[i] = 32'd0;
        end
        csr_m[CSR_CRMD] = 32'h0000_0008; // DA
        regs_m[0]       = 32'd0;
        reg_known       = 32'h1;
        tlb_v           = '0;
        victim_m        = 0;
        in_wb           = 1'b0;
        wb_m            = '0;

        repeat (4) @(posedge clk);
        #1;
        resetn = 1'b1;

        for (int i = 0; i < N_INSTR; i++) begin
            check_regs();
            check_wb();
            flushing = in_wb && causes_flush(wb_m);
            retire_model();
            make_instr(nv, nb);
            mem_to_wb_valid = nv;
            mem_to_wb_bus   = nb;
            x      = next_rand();
            raddr1 = x[4:0];
            raddr2 = x[9:5];
            in_wb  = nv && !flushing; // killed by the flush in this cycle
            wb_m   = nb;
            @(posedge clk);
            #1;
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* verilog/csr_file.sv */
`timescale 1ns/1ps

module csr_file #(
    parameter int TLB_NUM = 16
) (
    input  logic                       clk,
    input  logic                       resetn,
    input  wb_pkg::csr_req_t           csr_req,
    output logic [31:0]                csr_rvalue,
    output logic [$clog2(TLB_NUM)-1:0] tlb_idx,
    output logic [18:0]                tlb_ehi_vppn,
    output logic [31:0]                tlb_elo,
    output logic [9:0]                 tlb_asid,
    output logic                       tlb_we,
    output logic                       tlb_fill,
    output logic                       tlb_inv,
    input  wb_pkg::tlb_entry_t         tlb_rd_entry
);
    import wb_pkg::*;

    localparam int          IDX_W       = $clog2(TLB_NUM);
    localparam logic [31:0] TLBIDX_MASK = 32'h8000_0000 | (TLB_NUM - 1); // NE and index

    logic [31:0] crmd, prmd, estat, era, badv, eentry;
    logic [31:0] tlbidx, tlbehi, tlbelo0, asid, tid, tlbrentry, dmw0, dmw1;
    logic [31:0] rvalue;
    logic [31:0] wv, wm;

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] val,
                                          input logic [31:0] m);
        return (old & ~m) | (val & m);
    endfunction

    assign wv = csr_req.wvalue;
    assign wm = csr_req.wmask;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd      <= 32'h0000_0008; // DA=1
            prmd      <= '0;
            estat     <= '0;
            era       <= '0;
            badv      <= '0;
            eentry    <= '0;
            tlbidx    <= '0;
            tlbehi    <= '0;
            tlbelo0   <= '0;
            asid      <= '0;
            tid       <= '0;
            tlbrentry <= '0;
            dmw0      <= '0;
            dmw1      <= '0;
        end else begin
            if (csr_req.we) begin
                case (csr_req.num)
                    CSR_CRMD:      crmd      <= merge(crmd, wv, wm & 32'h0000_01ff);
                    CSR_PRMD:      prmd      <= merge(prmd, wv, wm & 32'h0000_0007);
                    CSR_ESTAT:     estat     <= merge(estat, wv, wm & 32'h0000_0003); // sw irq
                    CSR_ERA:       era       <= merge(era, wv, wm);
                    CSR_BADV:      badv      <= merge(badv, wv, wm);
                    CSR_EENTRY:    eentry    <= merge(eentry, wv, wm & 32'hffff_ffc0);
                    CSR_TLBIDX:    tlbidx    <= merge(tlbidx, wv, wm & TLBIDX_MASK);
                    CSR_TLBEHI:    tlbehi    <= merge(tlbehi, wv, wm & 32'hffff_e000);
                    CSR_TLBELO0:   tlbelo0   <= merge(tlbelo0, wv, wm & 32'h0fff_ff7f);
                    CSR_ASID:      asid      <= merge(asid, wv, wm & 32'h0000_03ff);
                    CSR_TID:       tid       <= merge(tid, wv, wm);
                    CSR_TLBRENTRY: tlbrentry <= merge(tlbrentry, wv, wm & 32'hffff_ffc0);
                    CSR_DMW0:      dmw0      <= merge(dmw0, wv, wm & 32'hee00_0039);
                    CSR_DMW1:      dmw1      <= merge(dmw1, wv, wm & 32'hee00_0039);
                    default: ;
                endcase
            end

            if (csr_req.ex) begin
                prmd[2:0]    <= crmd[2:0]; // PPLV, PIE
                crmd[2:0]    <= 3'b000;
                estat[30:16] <= {csr_req.esubcode, csr_req.ecode};
                era          <= csr_req.ex_pc;
                if (csr_req.ecode inside {ECODE_ADEF, ECODE_TLBR}) begin
                    badv <= csr_req.badv;
                end
            end

            if (csr_req.ertn) begin
                crmd[2:0] <= prmd[2:0];
            end

            case (csr_req.tlb_op)
                TLB_SRCH: begin
                    tlbidx[31] <= !csr_req.srch_found;
                    if (csr_req.srch_found) begin
                        tlbidx[IDX_W-1:0] <= IDX_W'(csr_req.srch_idx);
                    end
                end
                TLB_RD: begin
                    if (tlb_rd_entry.e) begin
                        tlbidx[31] <= 1'b0;
                        tlbehi     <= {tlb_rd_entry.vppn, 13'b0};
                        tlbelo0    <= {4'b0, tlb_rd_entry.ppn, 4'b0, tlb_rd_entry.plv, 2'b01};
                        asid[9:0]  <= tlb_rd_entry.asid;
                    end else begin
                        tlbidx[31] <= 1'b1; // empty slot
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (csr_req.num)
            CSR_CRMD:      rvalue = crmd;
            CSR_PRMD:      rvalue = prmd;
            CSR_ESTAT:     rvalue = estat;
            CSR_ERA:       rvalue = era;
            CSR_BADV:      rvalue = badv;
            CSR_EENTRY:    rvalue = eentry;
            CSR_TLBIDX:    rvalue = tlbidx;
            CSR_TLBEHI:    rvalue = tlbehi;
            CSR_TLBELO0:   rvalue = tlbelo0;
            CSR_ASID:      rvalue = asid;
            CSR_TID:       rvalue = tid;
            CSR_TLBRENTRY: rvalue = tlbrentry;
            CSR_DMW0:      rvalue = dmw0;
            CSR_DMW1:      rvalue = dmw1;
            default:       rvalue = 32'b0;
        endcase
    end

    assign csr_rvalue = csr_req.re ? rvalue : 32'b0;

    // bit 0 of the outgoing elo is the valid of a written entry
    assign tlb_idx      = tlbidx[IDX_W-1:0];
    assign tlb_ehi_vppn = tlbehi[31:13];
    assign tlb_elo      = {tlbelo0[31:1], !tlbidx[31]};
    assign tlb_asid     = asid[9:0];
    assign tlb_we       = csr_req.tlb_op == TLB_WR;
    assign tlb_fill     = csr_req.tlb_op == TLB_FILL;
    assign tlb_inv      = csr_req.tlb_op == TLB_INV;

    // a found search index has to fit the tlb before it lands in tlbidx
    a_tlbidx_range: assert property (@(posedge clk) disable iff (!resetn)
        (csr_req.tlb_op == TLB_SRCH && csr_req.srch_found) |->
            int'(csr_req.srch_idx) < TLB_NUM);

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic           clk,
    input  wb_pkg::rf_wb_t rf_wb,
    input  logic [4:0]     raddr1,
    input  logic [4:0]     raddr2,
    output logic [31:0]    rdata1,
    output logic [31:0]    rdata2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rf_wb.we && rf_wb.waddr != 5'd0) begin
            regs[rf_wb.waddr] <= rf_wb.wdata;
        end
    end

    // r0 is hardwired zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'b0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'b0 : regs[raddr2];

endmodule

/* verilog/tlb_array.sv */
`timescale 1ns/1ps

module tlb_array #(
    parameter int TLB_NUM = 16
) (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic [$clog2(TLB_NUM)-1:0] idx,
    input  logic [18:0]                ehi_vppn,
    input  logic [31:0]                elo,
    input  logic [9:0]                 asid,
    input  logic                       we,
    input  logic                       fill,
    input  logic                       inv,
    output wb_pkg::tlb_entry_t         rd_entry
);
    import wb_pkg::*;

    localparam int IDX_W = $clog2(TLB_NUM);

    tlb_entry_t         entries [TLB_NUM];
    logic [TLB_NUM-1:0] valid;
    logic [IDX_W-1:0]   victim;  // fill pointer
    logic [IDX_W-1:0]   wr_idx;
    tlb_entry_t         new_entry;

    assign new_entry = '{e: elo[0], vppn: ehi_vppn, asid: asid, ppn: elo[27:8], plv: elo[3:2]};
    assign wr_idx    = fill ? victim : idx;

    always_ff @(posedge clk) begin
        if (we || fill) begin
            entries[wr_idx] <= new_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid  <= '0;
            victim <= '0;
        end else begin
            if (inv) begin
                valid <= '0; // invalidate-all only
            end else if (we || fill) begin
                valid[wr_idx] <= new_entry.e;
            end
            if (fill) begin
                victim <= (victim == IDX_W'(TLB_NUM - 1)) ? '0 : victim + 1'b1;
            end
        end
    end

    always_comb begin
        rd_entry   = entries[idx];
        rd_entry.e = valid[idx];
    end

    a_we_fill_excl: assert property (@(posedge clk) disable iff (!resetn) !(we && fill));

endmodule

/* verilog/wb_pkg.sv */
package wb_pkg;

    // implemented csr numbers
    typedef enum logic [13:0] {
        CSR_CRMD      = 14'h000,
        CSR_PRMD      = 14'h001,
        CSR_ESTAT     = 14'h005,
        CSR_ERA       = 14'h006,
        CSR_BADV      = 14'h007,
        CSR_EENTRY    = 14'h00c,
        CSR_TLBIDX    = 14'h010,
        CSR_TLBEHI    = 14'h011,
        CSR_TLBELO0   = 14'h012,
        CSR_ASID      = 14'h018,
        CSR_TID       = 14'h040,
        CSR_TLBRENTRY = 14'h088,
        CSR_DMW0      = 14'h180,
        CSR_DMW1      = 14'h181
    } csr_num_e;

    typedef enum logic [2:0] {
        TLB_NONE,
        TLB_SRCH,
        TLB_WR,
        TLB_FILL,
        TLB_RD,
        TLB_INV
    } tlb_op_e;

    typedef enum logic [5:0] {
        ECODE_ADEF = 6'h08,
        ECODE_SYS  = 6'h0b,
        ECODE_BRK  = 6'h0c,
        ECODE_INE  = 6'h0d,
        ECODE_TLBR = 6'h3f
    } ecode_e;

    // memory stage -> writeback
    typedef struct packed {
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] rf_wdata;
        logic [31:0] pc;
        logic        read_tid;      // rdcntid
        logic        csr_re;
        logic        csr_we;
        csr_num_e    csr_num;
        logic [31:0] csr_wmask;
        logic [31:0] csr_wvalue;
        logic        ertn;
        logic        excep_en;
        ecode_e      ecode;
        logic [8:0]  esubcode;
        logic [31:0] badv;
        tlb_op_e     tlb_op;
        logic        srch_conflict; // tlbsrch waits on a csr write in wb
        logic        srch_found;
        logic [3:0]  srch_idx;
    } mem_wb_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } rf_wb_t;

    // writeback -> csr file
    typedef struct packed {
        logic        re;
        csr_num_e    num;
        logic        we;
        logic [31:0] wmask;
        logic [31:0] wvalue;
        logic        ex;
        ecode_e      ecode;
        logic [8:0]  esubcode;
        logic [31:0] ex_pc;
        logic [31:0] badv;
        logic        ertn;
        tlb_op_e     tlb_op;
        logic        srch_found;
        logic [3:0]  srch_idx;
    } csr_req_t;

    typedef struct packed {
        logic        e;
        logic [18:0] vppn;
        logic [9:0]  asid;
        logic [19:0] ppn;
        logic [1:0]  plv;
    } tlb_entry_t;

endpackage

/* verilog/wb_stage.sv */
`timescale 1ns/1ps

module wb_stage (
    input  logic             clk,
    input  logic             resetn,
    input  logic             mem_to_wb_valid,
    input  wb_pkg::mem_wb_t  mem_to_wb_bus,
    output logic             wb_allowin,
    output wb_pkg::csr_req_t csr_req,
    input  logic [31:0]      csr_rvalue,
    output wb_pkg::rf_wb_t   rf_wb,
    output logic             ex_flush,
    output logic             ertn_flush,
    output logic             refetch_flush,
    output logic [31:0]      flush_entry,
    output logic             wb_to_ex_conflict,
    output logic [31:0]      debug_wb_pc,
    output logic [3:0]       debug_wb_rf_we,
    output logic [4:0]       debug_wb_rf_wnum,
    output logic [31:0]      debug_wb_rf_wdata
);
    import wb_pkg::*;

    logic        wb_valid;
    mem_wb_t     wb_bus;
    logic        wb_ok;        // valid and retiring normally
    logic        csr_refetch;
    logic        tlb_refetch;
    logic [31:0] final_wdata;

    assign wb_allowin = 1'b1; // wb never stalls

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (ex_flush || ertn_flush || refetch_flush) begin
            wb_valid <= 1'b0; // kills whatever mem sends this cycle
        end else if (wb_allowin) begin
            wb_valid <= mem_to_wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_to_wb_valid && wb_allowin) begin
            wb_bus <= mem_to_wb_bus;
        end
    end

    assign ex_flush   = wb_valid && wb_bus.excep_en;
    assign ertn_flush = wb_valid && wb_bus.ertn;
    assign wb_ok      = wb_valid && !wb_bus.excep_en && !wb_bus.ertn;

    // address translation state may change, so refetch from pc+4
    assign tlb_refetch = wb_bus.tlb_op inside {TLB_WR, TLB_FILL, TLB_RD, TLB_INV};
    assign csr_refetch = wb_bus.csr_we &&
                         (wb_bus.csr_num inside {CSR_CRMD, CSR_ASID, CSR_DMW0, CSR_DMW1});
    assign refetch_flush = wb_ok && (tlb_refetch || csr_refetch);

    assign flush_entry = (ex_flush || ertn_flush) ? csr_rvalue : wb_bus.pc + 32'd4;

    assign final_wdata = (wb_bus.csr_re || wb_bus.read_tid) ? csr_rvalue : wb_bus.rf_wdata;

    always_comb begin
        csr_req.re = ex_flush || ertn_flush || (wb_valid && (wb_bus.csr_re || wb_bus.read_tid));
        if (ex_flush) begin
            csr_req.num = (wb_bus.ecode == ECODE_TLBR) ? CSR_TLBRENTRY : CSR_EENTRY;
        end else if (ertn_flush) begin
            csr_req.num = CSR_ERA;
        end else if (wb_bus.read_tid) begin
            csr_req.num = CSR_TID;
        end else begin
            csr_req.num = wb_bus.csr_num;
        end
        csr_req.we         = wb_ok && wb_bus.csr_we;
        csr_req.wmask      = wb_bus.csr_wmask;
        csr_req.wvalue     = wb_bus.csr_wvalue;
        csr_req.ex         = ex_flush;
        csr_req.ecode      = wb_bus.ecode;
        csr_req.esubcode   = wb_bus.esubcode;
        csr_req.ex_pc      = wb_bus.pc;
        csr_req.badv       = wb_bus.badv;
        csr_req.ertn       = ertn_flush;
        csr_req.tlb_op     = wb_ok ? wb_bus.tlb_op : TLB_NONE;
        csr_req.srch_found = wb_bus.srch_found;
        csr_req.srch_idx   = wb_bus.srch_idx;
    end

    assign rf_wb.we    = wb_ok && wb_bus.rf_we;
    assign rf_wb.waddr = wb_bus.rf_waddr;
    assign rf_wb.wdata = final_wdata;

    assign wb_to_ex_conflict = wb_valid && wb_bus.srch_conflict;

    assign debug_wb_pc       = wb_bus.pc;
    assign debug_wb_rf_we    = {4{rf_wb.we}};
    assign debug_wb_rf_wnum  = wb_bus.rf_waddr;
    assign debug_wb_rf_wdata = final_wdata;

    // the memory stage must not mark one instruction as both
    a_ex_ertn_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(ex_flush && ertn_flush));

endmodule

/* verilog/wb_subsys_top.sv */
`timescale 1ns/1ps

module wb_subsys_top #(
    parameter int TLB_NUM = 16
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            mem_to_wb_valid,
    input  wb_pkg::mem_wb_t mem_to_wb_bus,
    output logic            wb_allowin,
    output logic            ex_flush,
    output logic            ertn_flush,
    output logic            refetch_flush,
    output logic [31:0]     flush_entry,
    output logic            wb_to_ex_conflict,
    output logic [31:0]     debug_wb_pc,
    output logic [3:0]      debug_wb_rf_we,
    output logic [4:0]      debug_wb_rf_wnum,
    output logic [31:0]     debug_wb_rf_wdata,
    output wb_pkg::rf_wb_t  rf_wb,
    input  logic [4:0]      raddr1,
    input  logic [4:0]      raddr2,
    output logic [31:0]     rdata1,
    output logic [31:0]     rdata2
);
    import wb_pkg::*;

    csr_req_t                   csr_req;
    logic [31:0]                csr_rvalue;
    logic [$clog2(TLB_NUM)-1:0] tlb_idx;
    logic [18:0]                tlb_ehi_vppn;
    logic [31:0]                tlb_elo;
    logic [9:0]                 tlb_asid;
    logic                       tlb_we, tlb_fill, tlb_inv;
    tlb_entry_t                 tlb_rd_entry;

    wb_stage i_wb_stage (
        .clk               (clk),
        .resetn            (resetn),
        .mem_to_wb_valid   (mem_to_wb_valid),
        .mem_to_wb_bus     (mem_to_wb_bus),
        .wb_allowin        (wb_allowin),
        .csr_req           (csr_req),
        .csr_rvalue        (csr_rvalue),
        .rf_wb             (rf_wb),
        .ex_flush          (ex_flush),
        .ertn_flush        (ertn_flush),
        .refetch_flush     (refetch_flush),
        .flush_entry       (flush_entry),
        .wb_to_ex_conflict (wb_to_ex_conflict),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    csr_file #(.TLB_NUM(TLB_NUM)) i_csr_file (
        .clk          (clk),
        .resetn       (resetn),
        .csr_req      (csr_req),
        .csr_rvalue   (csr_rvalue),
        .tlb_idx      (tlb_idx),
        .tlb_ehi_vppn (tlb_ehi_vppn),
        .tlb_elo      (tlb_elo),
        .tlb_asid     (tlb_asid),
        .tlb_we       (tlb_we),
        .tlb_fill     (tlb_fill),
        .tlb_inv      (tlb_inv),
        .tlb_rd_entry (tlb_rd_entry)
    );

    reg_file i_reg_file (
        .clk    (clk),
        .rf_wb  (rf_wb),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    tlb_array #(.TLB_NUM(TLB_NUM)) i_tlb_array (
        .clk      (clk),
        .resetn   (resetn),
        .idx      (tlb_idx),
        .ehi_vppn (tlb_ehi_vppn),
        .elo      (tlb_elo),
        .asid     (tlb_asid),
        .we       (tlb_we),
        .fill     (tlb_fill),
        .inv      (tlb_inv),
        .rd_entry (tlb_rd_entry)
    );

endmodule
